//--- src/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

   // write side is one byte, read side one word
   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = 32;

   localparam int N_LANES = R_DATA_W / W_DATA_W;
   localparam int LANE_W = $clog2(N_LANES);

   // largest depth exponent the address types can carry
   localparam int MAX_ADDR_W = 8;

   localparam int CREDIT_W = 3;

   typedef logic [W_DATA_W-1:0] wdata_t;

   typedef logic [R_DATA_W-1:0] rdata_t;

   // byte slot, modules use the low ADDR_W bits
   typedef logic [MAX_ADDR_W-1:0] baddr_t;

   // word slot inside one lane bank
   typedef logic [MAX_ADDR_W-LANE_W-1:0] waddr_t;

   // fill count in bytes, one extra bit so a full FIFO fits
   typedef logic [MAX_ADDR_W:0] level_t;

   typedef logic [CREDIT_W-1:0] credit_t;

endpackage

//--- src/fifo_bus_pkg.sv
package fifo_bus_pkg;

   // write port of one lane bank
   typedef struct packed {
      logic                 en;
      fifo_cfg_pkg::waddr_t addr;
      fifo_cfg_pkg::wdata_t data;
   } bank_wr_t;

   // read port, same word address for every lane
   typedef struct packed {
      logic                 en;
      fifo_cfg_pkg::waddr_t addr;
   } bank_rd_t;

   // credits handed back to the producer
   typedef struct packed {
      logic                  valid;
      fifo_cfg_pkg::credit_t count;
   } credit_ret_t;

endpackage

//--- src/ram_2p_bank.sv
`timescale 1ns/1ps

module ram_2p_bank #(
   parameter int ADDR_W = 6
) (
   input  logic                   clk_i,
   input  fifo_bus_pkg::bank_wr_t wr_i,
   input  fifo_bus_pkg::bank_rd_t rd_i,
   output fifo_cfg_pkg::wdata_t   rd_data_o
);

   localparam int BANK_AW = ADDR_W - fifo_cfg_pkg::LANE_W;
   localparam int DEPTH = 2 ** BANK_AW;

   fifo_cfg_pkg::wdata_t mem [DEPTH];

   always_ff @(posedge clk_i) begin
      if (wr_i.en) begin
         mem[wr_i.addr[BANK_AW-1:0]] <= wr_i.data;
      end
   end

   // registered read, output holds between reads
   always_ff @(posedge clk_i) begin
      if (rd_i.en) begin
         rd_data_o <= mem[rd_i.addr[BANK_AW-1:0]];
      end
   end

endmodule

//--- src/ram_2p_asym.sv
`timescale 1ns/1ps

module ram_2p_asym #(
   parameter int ADDR_W = 6
) (
   input  logic                                                   clk_i,
   input  logic                                                   w_en_i,
   input  fifo_cfg_pkg::baddr_t                                   w_addr_i,
   input  fifo_cfg_pkg::wdata_t                                   w_data_i,
   input  logic                                                   r_en_i,
   input  fifo_cfg_pkg::waddr_t                                   r_addr_i,
   output fifo_bus_pkg::bank_wr_t [fifo_cfg_pkg::N_LANES-1:0]     ext_wr_o,
   output fifo_bus_pkg::bank_rd_t                                 ext_rd_o,
   input  fifo_cfg_pkg::rdata_t                                   ext_rd_data_i,
   output fifo_cfg_pkg::rdata_t                                   r_data_o
);

   localparam int LANE_W = fifo_cfg_pkg::LANE_W;
   localparam int W_DATA_W = fifo_cfg_pkg::W_DATA_W;

   logic [LANE_W-1:0]    w_lane;
   fifo_cfg_pkg::waddr_t w_word;
   logic                 rd_pend_q;

   // low bits pick the lane, the rest is the word slot
   assign w_lane = w_addr_i[LANE_W-1:0];
   assign w_word = fifo_cfg_pkg::waddr_t'(w_addr_i[ADDR_W-1:LANE_W]);

   always_comb begin
      for (int i = 0; i < fifo_cfg_pkg::N_LANES; i++) begin
         ext_wr_o[i].en   = w_en_i && (w_lane == LANE_W'(i));
         ext_wr_o[i].addr = w_word;
         ext_wr_o[i].data = w_data_i;
      end
   end

   // every lane reads the same word slot
   assign ext_rd_o = '{en: r_en_i, addr: r_addr_i};

   // bank outputs are only meaningful the cycle after a read
   always_ff @(posedge clk_i) begin
      rd_pend_q <= r_en_i;
   end

   // lane 0 holds the oldest byte and goes lowest
   always_comb begin
      r_data_o = '0;
      if (rd_pend_q) begin
         for (int i = 0; i < fifo_cfg_pkg::N_LANES; i++) begin
            r_data_o[i*W_DATA_W +: W_DATA_W] = ext_rd_data_i[i*W_DATA_W +: W_DATA_W];
         end
      end
   end

endmodule

//--- src/fifo_level_ctrl.sv
`timescale 1ns/1ps

module fifo_level_ctrl #(
   parameter int ADDR_W = 6
) (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      w_en_i,
   input  logic                      r_en_i,
   output fifo_cfg_pkg::level_t      level_o,
   output logic                      empty_o,
   output logic                      full_o,
   output fifo_bus_pkg::credit_ret_t credit_o
);

   // capacity in bytes
   localparam fifo_cfg_pkg::level_t FIFO_SIZE = fifo_cfg_pkg::level_t'(1) << ADDR_W;
   localparam fifo_cfg_pkg::level_t WORD_BYTES = fifo_cfg_pkg::level_t'(fifo_cfg_pkg::N_LANES);
   localparam fifo_cfg_pkg::credit_t CREDIT = fifo_cfg_pkg::credit_t'(fifo_cfg_pkg::N_LANES);

   fifo_cfg_pkg::level_t level_nxt;
   logic                 credit_vld_q;

   // one byte in per write, one word out per read
   always_comb begin
      level_nxt = level_o;
      if (w_en_i) begin
         level_nxt = level_nxt + fifo_cfg_pkg::level_t'(1);
      end
      if (r_en_i) begin
         level_nxt = level_nxt - WORD_BYTES;
      end
   end

   // flags follow the next level so they line up with level_o
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         level_o <= '0;
         empty_o <= 1'b1;
         full_o  <= 1'b0;
      end else begin
         level_o <= level_nxt;
         empty_o <= (level_nxt < WORD_BYTES);
         full_o  <= (level_nxt > (FIFO_SIZE - fifo_cfg_pkg::level_t'(1)));
      end
   end

   // a word read frees four byte slots
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         credit_vld_q <= 1'b0;
      end else begin
         credit_vld_q <= r_en_i;
      end
   end

   assign credit_o = '{valid: credit_vld_q, count: CREDIT};

endmodule

//--- src/fifo_sync_asym.sv
`timescale 1ns/1ps

module fifo_sync_asym #(
   parameter int ADDR_W = 6
) (
   input  logic                                               clk_i,
   input  logic                                               reset_i,
   input  logic                                               w_en_i,
   input  fifo_cfg_pkg::wdata_t                               w_data_i,
   output fifo_bus_pkg::credit_ret_t                          credit_o,
   input  logic                                               r_en_i,
   output fifo_cfg_pkg::rdata_t                               r_data_o,
   output logic                                               r_valid_o,
   output logic                                               r_empty_o,
   output fifo_cfg_pkg::level_t                               level_o,
   output fifo_bus_pkg::bank_wr_t [fifo_cfg_pkg::N_LANES-1:0] ext_wr_o,
   output fifo_bus_pkg::bank_rd_t                             ext_rd_o,
   input  fifo_cfg_pkg::rdata_t                               ext_rd_data_i
);

   localparam int R_ADDR_W = ADDR_W - fifo_cfg_pkg::LANE_W;

   logic                w_full;
   logic                w_en_int;
   logic                r_en_int;
   logic [ADDR_W-1:0]   w_addr_q;
   logic [R_ADDR_W-1:0] r_addr_q;

   // full never leaves the core, it only guards writes
   assign w_en_int = w_en_i && !w_full;
   assign r_en_int = r_en_i && !r_empty_o;

   // byte pointer on the write side, word pointer on the read side
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         w_addr_q  <= '0;
         r_addr_q  <= '0;
         r_valid_o <= 1'b0;
      end else begin
         if (w_en_int) begin
            w_addr_q <= w_addr_q + 1'b1;
         end
         if (r_en_int) begin
            r_addr_q <= r_addr_q + 1'b1;
         end
         r_valid_o <= r_en_int;
      end
   end

   fifo_level_ctrl #(
      .ADDR_W (ADDR_W)
   ) level_ctrl (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .w_en_i   (w_en_int),
      .r_en_i   (r_en_int),
      .level_o  (level_o),
      .empty_o  (r_empty_o),
      .full_o   (w_full),
      .credit_o (credit_o)
   );

   ram_2p_asym #(
      .ADDR_W (ADDR_W)
   ) mem_adapter (
      .clk_i         (clk_i),
      .w_en_i        (w_en_int),
      .w_addr_i      (fifo_cfg_pkg::baddr_t'(w_addr_q)),
      .w_data_i      (w_data_i),
      .r_en_i        (r_en_int),
      .r_addr_i      (fifo_cfg_pkg::waddr_t'(r_addr_q)),
      .ext_wr_o      (ext_wr_o),
      .ext_rd_o      (ext_rd_o),
      .ext_rd_data_i (ext_rd_data_i),
      .r_data_o      (r_data_o)
   );

endmodule

//--- src/asym_fifo_top.sv
`timescale 1ns/1ps

module asym_fifo_top #(
   parameter int ADDR_W = 6
) (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      w_en_i,
   input  fifo_cfg_pkg::wdata_t      w_data_i,
   output fifo_bus_pkg::credit_ret_t credit_o,
   input  logic                      r_en_i,
   output fifo_cfg_pkg::rdata_t      r_data_o,
   output logic                      r_valid_o,
   output logic                      r_empty_o,
   output fifo_cfg_pkg::level_t      level_o
);

   localparam int W_DATA_W = fifo_cfg_pkg::W_DATA_W;

   fifo_bus_pkg::bank_wr_t [fifo_cfg_pkg::N_LANES-1:0] ext_wr;
   fifo_bus_pkg::bank_rd_t                             ext_rd;
   wire fifo_cfg_pkg::rdata_t                          ext_rd_data;

   fifo_sync_asym #(
      .ADDR_W (ADDR_W)
   ) fifo_core (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .w_en_i        (w_en_i),
      .w_data_i      (w_data_i),
      .credit_o      (credit_o),
      .r_en_i        (r_en_i),
      .r_data_o      (r_data_o),
      .r_valid_o     (r_valid_o),
      .r_empty_o     (r_empty_o),
      .level_o       (level_o),
      .ext_wr_o      (ext_wr),
      .ext_rd_o      (ext_rd),
      .ext_rd_data_i (ext_rd_data)
   );

   // one bank per byte lane
   for (genvar i = 0; i < fifo_cfg_pkg::N_LANES; i++) begin : g_lane
      ram_2p_bank #(
         .ADDR_W (ADDR_W)
      ) bank (
         .clk_i     (clk_i),
         .wr_i      (ext_wr[i]),
         .rd_i      (ext_rd),
         .rd_data_o (ext_rd_data[i*W_DATA_W +: W_DATA_W])
      );
   end

endmodule

//--- verification/asym_fifo_properties.sv
`timescale 1ns/1ps

module asym_fifo_properties #(
   parameter int ADDR_W = 6
) (
   input logic                      clk_i,
   input logic                      reset_i,
   input logic                      w_en_i,
   input logic                      r_en_i,
   input logic                      r_valid_o,
   input logic                      r_empty_o,
   input fifo_bus_pkg::credit_ret_t credit_o,
   input fifo_cfg_pkg::level_t      level_o
);

   localparam fifo_cfg_pkg::level_t FIFO_BYTES = fifo_cfg_pkg::level_t'(1) << ADDR_W;
   localparam fifo_cfg_pkg::level_t WORD_BYTES = fifo_cfg_pkg::level_t'(4);

   int   fail_cnt = 0;
   logic rd_acc;

   assign rd_acc = r_en_i && !r_empty_o;

   a_valid_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
      rd_acc |=> r_valid_o)
      else begin fail_cnt++; $error("r_valid_o missing after accepted read"); end

   a_no_stray_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      !rd_acc |=> !r_valid_o)
      else begin fail_cnt++; $error("r_valid_o without accepted read"); end

   // credits ride along with the read data
   a_credit_with_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      credit_o.valid == r_valid_o)
      else begin fail_cnt++; $error("credit pulse not aligned to r_valid_o"); end

   a_credit_count: assert property (@(posedge clk_i) disable iff (reset_i)
      credit_o.valid |-> (credit_o.count == 3'd4))
      else begin fail_cnt++; $error("credit pulse count is not four"); end

   a_no_write_full: assert property (@(posedge clk_i) disable iff (reset_i)
      !(w_en_i && (level_o >= FIFO_BYTES)))
      else begin fail_cnt++; $error("write raised while FIFO is full"); end

   a_empty_flag: assert property (@(posedge clk_i) disable iff (reset_i)
      r_empty_o == (level_o < WORD_BYTES))
      else begin fail_cnt++; $error("r_empty_o does not match level"); end

endmodule

//--- verification/asym_fifo_tb.sv
`timescale 1ns/1ps

module asym_fifo_tb;

   localparam int ADDR_W = 6;
   localparam int FIFO_BYTES = 2 ** ADDR_W;
   localparam int PRELOAD_BYTES = 16;
   localparam int FILL_TRIES = FIFO_BYTES + 8;
   localparam int CREDIT_READS = 3;
   localparam int MIX_CYCLES = 600;
   localparam int DRAIN_LIMIT = 200;
   // reset, every phase, and each of the three drains at its guard limit
   localparam int STIM_CYCLES = 4 + 1 + PRELOAD_BYTES + FILL_TRIES + 1 + 2 * CREDIT_READS + 1
                                + MIX_CYCLES + 4 + 3 * (DRAIN_LIMIT + 1);
   localparam int TIMEOUT_NS = 4 * (STIM_CYCLES + 200) * 40;

   logic                      clk_i;
   logic                      reset_i;
   logic                      w_en_i;
   fifo_cfg_pkg::wdata_t      w_data_i;
   fifo_bus_pkg::credit_ret_t credit_o;
   logic                      r_en_i;
   fifo_cfg_pkg::rdata_t      r_data_o;
   logic                      r_valid_o;
   logic                      r_empty_o;
   fifo_cfg_pkg::level_t      level_o;

   // model state kept on rising edges
   logic [7:0]  byte_q[$];
   int          exp_level = 0;
   int          credits = FIFO_BYTES;
   logic        exp_valid = 1'b0;
   logic [31:0] exp_word = '0;
   logic [15:0] lfsr = 16'd18;
   int          err_seq = 0;
   int          err_mon = 0;

   asym_fifo_top #(
      .ADDR_W (ADDR_W)
   ) dut (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .credit_o  (credit_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_valid_o (r_valid_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o)
   );

   bind asym_fifo_top asym_fifo_properties #(.ADDR_W(ADDR_W)) props (
      .clk_i (clk_i), .reset_i (reset_i), .w_en_i (w_en_i), .r_en_i (r_en_i),
      .r_valid_o (r_valid_o), .r_empty_o (r_empty_o), .credit_o (credit_o),
      .level_o (level_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // fibonacci lfsr with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[6:0], lfsr[15]};
      end
   endtask

   function automatic bit value_ok(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
      assert (got === exp)
         else $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      return got === exp;
   endfunction

   // decide at the falling edge, drive at the rising edge
   task automatic drive_cycle(input bit want_w, input bit want_r, output bit empty_seen);
      bit         go;
      logic [7:0] d;
      @(negedge clk_i);
      empty_seen = r_empty_o;
      go = want_w && ((credits - int'(w_en_i)) > 0);
      d = '0;
      if (go) begin
         take_bits(8, d);
      end
      @(posedge clk_i);
      w_en_i   <= go;
      w_data_i <= d;
      r_en_i   <= want_r;
   endtask

   task automatic drain_fifo();
      bit e;
      int guard;
      e = 1'b0;
      guard = 0;
      while (!e && guard < DRAIN_LIMIT) begin
         drive_cycle(1'b0, 1'b1, e);
         guard++;
      end
      drive_cycle(1'b0, 1'b0, e);
      if (guard >= DRAIN_LIMIT) begin
         $display("drain never saw the FIFO go empty");
         err_seq++;
      end
   endtask

   // model accepts enables by the level it tracks itself
   always @(posedge clk_i) begin
      if (reset_i) begin
         exp_level = 0;
         exp_valid = 1'b0;
         credits = FIFO_BYTES;
         byte_q.delete();
      end else begin
         logic rd_acc;
         rd_acc = r_en_i && (exp_level >= 4);
         if (credit_o.valid) begin
            credits = credits + int'(credit_o.count);
         end
         if (w_en_i && exp_level < FIFO_BYTES) begin
            byte_q.push_back(w_data_i);
            exp_level = exp_level + 1;
            credits = credits - 1;
         end
         if (rd_acc) begin
            // oldest byte lands in lane 0
            exp_word = {byte_q[3], byte_q[2], byte_q[1], byte_q[0]};
            repeat (4) void'(byte_q.pop_front());
            exp_level = exp_level - 4;
         end
         exp_valid = rd_acc;
      end
   end

   always @(negedge clk_i) begin
      if (!reset_i) begin
         if (!value_ok("level_o", 32'(level_o), 32'(exp_level))) err_mon++;
         if (!value_ok("r_empty_o", 32'(r_empty_o), 32'(exp_level < 4))) err_mon++;
         if (!value_ok("r_valid_o", 32'(r_valid_o), 32'(exp_valid))) err_mon++;
         if (!value_ok("credit_o.valid", 32'(credit_o.valid), 32'(exp_valid))) err_mon++;
         if (exp_valid && !value_ok("r_data_o", r_data_o, exp_word)) err_mon++;
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired before the tests finished");
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      bit e;
      bit bw;
      bit br;
      int total;
      logic [7:0] rb;
      reset_i  = 1'b1;
      w_en_i   = 1'b0;
      w_data_i = '0;
      r_en_i   = 1'b0;
      repeat (4) @(posedge clk_i);
      reset_i <= 1'b0;

      @(negedge clk_i);
      if (!value_ok("r_empty_o", 32'(r_empty_o), 32'd1)) err_seq++;
      if (!value_ok("r_valid_o", 32'(r_valid_o), 32'd0)) err_seq++;
      if (!value_ok("credit_o.valid", 32'(credit_o.valid), 32'd0)) err_seq++;
      if (!value_ok("level_o", 32'(level_o), 32'd0)) err_seq++;

      // ordered bytes out as words
      repeat (PRELOAD_BYTES) drive_cycle(1'b1, 1'b0, e);
      drain_fifo();

      // fill until credits run out
      repeat (FILL_TRIES) drive_cycle(1'b1, 1'b0, e);
      @(negedge clk_i);
      if (!value_ok("credits", 32'(credits), 32'd0)) err_seq++;
      if (!value_ok("level_o", 32'(level_o), 32'(FIFO_BYTES))) err_seq++;
      repeat (CREDIT_READS) drive_cycle(1'b0, 1'b1, e);
      repeat (CREDIT_READS) drive_cycle(1'b0, 1'b0, e);
      @(negedge clk_i);
      if (!value_ok("credits", 32'(credits), 32'(4 * CREDIT_READS))) err_seq++;
      drain_fifo();

      // mixed traffic where reads also hit an empty FIFO
      repeat (MIX_CYCLES) begin
         take_bits(1, rb);
         bw = rb[0];
         take_bits(1, rb);
         br = rb[0];
         drive_cycle(bw, br, e);
      end
      drain_fifo();
      repeat (4) drive_cycle(1'b0, 1'b0, e);

      total = err_seq + err_mon + dut.props.fail_cnt;
      $display("errors: sequence %0d, monitor %0d, assertions %0d",
               err_seq, err_mon, dut.props.fail_cnt);
      if (total == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
src/fifo_cfg_pkg.sv
src/fifo_bus_pkg.sv
src/ram_2p_bank.sv
src/ram_2p_asym.sv
src/fifo_level_ctrl.sv
src/fifo_sync_asym.sv
src/asym_fifo_top.sv
verification/asym_fifo_properties.sv
verification/asym_fifo_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -sv
TOP      := asym_fifo_tb
FILELIST := files.f
LOG      := sim.log
PASS     := Result: PASSED

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
